// File: game_defines.svh
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// Screen and player geometry in pixels
`define SCREEN_W        640
`define SCREEN_H        480
`define P1_START        32'h0160_0064 // x 352, y 100
`define P2_START        32'h0190_0064 // x 400, y 100
`define P1_SIZE         32'h0028_003C // 40 by 60
`define P2_SIZE         32'h0028_003C
`define GRAVITY_RST     1
`define STAGE_POS_RST   32'h0064_012C // x 100, y 300
`define STAGE_SIZE_RST  32'h01B8_0028 // 440 by 40

// Motion constants, per physics tick
`define WALK_STEP       2
`define JUMP_V          8
`define VY_MAX          6
`define REACH           16
`define KNOCK           3
`define PHYS_DIV        4

// Controller bits
`define BTN_LEFT        0
`define BTN_RIGHT       1
`define BTN_JUMP        2
`define BTN_ATTACK      3

// Coprocessor block numbers, address bits 11:7
`define SEL_POS1        5'd0
`define SEL_POS2        5'd1
`define SEL_CTRL1       5'd4
`define SEL_CTRL2       5'd5
`define SEL_COLL1       5'd12
`define SEL_COLL2       5'd13
`define SEL_ATK1        5'd16
`define SEL_ATK2        5'd17
`define SEL_CFG         5'd31

// Registers of the config block, address bits 6:2
`define CFG_GRAVITY     5'd0
`define CFG_STAGE_POS   5'd1
`define CFG_STAGE_SIZE  5'd2

`endif

// File: game_pkg.sv
package game_pkg;

	// Screen coordinates, origin top left
	typedef struct packed {
		logic [15:0] x; // Upper half of the word
		logic [15:0] y; // Lower half
	} xy_t;

	// Position or size word
	// Bus side sees raw, coprocessors see xy
	typedef union packed {
		logic [31:0] raw;
		xy_t         xy;
	} pos_word_u;

endpackage

// File: phys_if.sv
`timescale 1ns/100ps

// Hub to physics core link, one per player
interface phys_if;
	logic [3:0]          ctrl;    // Synchronized buttons
	logic [3:0]          wall;    // Collision bits
	logic                hit;     // Opponent's attack landed
	logic signed [15:0]  knock;   // Knockback per tick
	logic [15:0]         gravity; // Added to vy while airborne
	game_pkg::pos_word_u pos;     // Current position

	modport hub (
		output ctrl,
		output wall,
		output hit,
		output knock,
		output gravity,
		input  pos
	);

	modport core (
		input  ctrl,
		input  wall,
		input  hit,
		input  knock,
		input  gravity,
		output pos
	);
endinterface

// File: dmem.sv
`timescale 1ns/100ps

// Word addressed data memory, read data one cycle after address
module dmem (
	input  logic        clock,
	input  logic [11:0] address,
	input  logic [31:0] data,
	input  logic        wren,
	output logic [31:0] q
);
	localparam int DEPTH = 1 << $bits(address); // 4096 words

	game_pkg::pos_word_u mem [DEPTH];

	always_ff @(posedge clock) begin
		if (wren) begin
			mem[address].raw <= data;
		end
		q <= mem[address].raw; // Old data on a write cycle
	end
endmodule

// File: collision.sv
`timescale 1ns/100ps
`include "game_defines.svh"

// Player box against stage and screen edges, purely combinational
module collision (
	input  game_pkg::pos_word_u player_pos,
	input  game_pkg::pos_word_u player_size,
	input  game_pkg::pos_word_u stage_pos,
	input  game_pkg::pos_word_u stage_size,
	output logic [3:0]          coll
);
	always_comb begin
		int px;
		int py;
		int pw;
		int ph;
		int sx;
		int sy;
		int sw;
		px = int'(player_pos.xy.x);
		py = int'(player_pos.xy.y);
		pw = int'(player_size.xy.x);
		ph = int'(player_size.xy.y);
		sx = int'(stage_pos.xy.x);
		sy = int'(stage_pos.xy.y); // Stage top
		sw = int'(stage_size.xy.x);

		// Floor needs x overlap, feet at or past top, head still above
		coll[0] = (px < sx + sw) && (px + pw > sx) && (py + ph >= sy) && (py < sy);
		coll[1] = (py == 0);                 // Ceiling
		coll[2] = (px == 0);                 // Left wall
		coll[3] = (px + pw >= `SCREEN_W);    // Right wall
	end

	// Holds only while the stage sits lower than one player height
	a_floor_ceiling: assert #0 (!((coll[0] === 1'b1) && (coll[1] === 1'b1)))
		else $error("Floor and ceiling set together");
endmodule

// File: attack_coprocessor.sv
`timescale 1ns/100ps
`include "game_defines.svh"

module attack_coprocessor (
	input  logic                clock,
	input  logic                arst_n,
	input  game_pkg::pos_word_u own_pos,
	input  game_pkg::pos_word_u own_size,
	input  game_pkg::pos_word_u foe_pos,
	input  game_pkg::pos_word_u foe_size,
	input  logic [3:0]          controls,
	output logic                hit,
	output logic signed [15:0]  knock
);
	logic               hit_d;
	logic signed [15:0] knock_d;

	always_comb begin
		int ox;
		int oy;
		int ow;
		int oh;
		int fx;
		int fy;
		int fw;
		int fh;
		logic in_reach;
		ox = int'(own_pos.xy.x);
		oy = int'(own_pos.xy.y);
		ow = int'(own_size.xy.x);
		oh = int'(own_size.xy.y);
		fx = int'(foe_pos.xy.x);
		fy = int'(foe_pos.xy.y);
		fw = int'(foe_size.xy.x);
		fh = int'(foe_size.xy.y);

		// Own box widened left and right by the reach
		in_reach = (ox - `REACH < fx + fw) && (ox + ow + `REACH > fx)
			&& (oy < fy + fh) && (oy + oh > fy);
		hit_d    = controls[`BTN_ATTACK] && in_reach;

		// Push foe away from attacker
		knock_d = (ox < fx) ? 16'(`KNOCK) : 16'(-`KNOCK);
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			hit   <= 1'b0;
			knock <= '0;
		end else begin
			hit   <= hit_d;
			knock <= knock_d;
		end
	end
endmodule

// File: physics_coprocessor.sv
`timescale 1ns/100ps
`include "game_defines.svh"

module physics_coprocessor #(
	parameter logic [31:0] START = 32'd0 // Position after reset
) (
	input logic  clock,
	input logic  arst_n,
	phys_if.core link
);
	localparam int CNT_W = $clog2(`PHYS_DIV);

	logic [CNT_W-1:0]    tick_cnt; // Free running, same phase in both cores
	logic                tick;
	game_pkg::pos_word_u pos_q;
	game_pkg::pos_word_u pos_d;
	logic signed [15:0]  vy_q;     // Positive is downward
	logic signed [15:0]  vy_d;

	assign tick = (tick_cnt == CNT_W'(`PHYS_DIV - 1));

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			tick_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0; // Wrap
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// Next position and speed, used only on a tick
	always_comb begin
		int x_n;
		int y_n;
		int v_n;
		x_n = int'(pos_q.xy.x);
		y_n = int'(pos_q.xy.y);
		v_n = int'(vy_q);

		// Horizontal, knockback overrides walking
		if (link.hit) begin
			x_n = x_n + int'(link.knock);
		end else begin
			if (link.ctrl[`BTN_LEFT] && !link.wall[2]) begin
				x_n = x_n - `WALK_STEP;
			end
			if (link.ctrl[`BTN_RIGHT] && !link.wall[3]) begin
				x_n = x_n + `WALK_STEP;
			end
		end
		if (x_n < 0) begin
			x_n = 0; // Stop at left screen edge
		end

		// Vertical
		if (link.wall[0]) begin // Standing on the stage
			if (link.ctrl[`BTN_JUMP]) begin
				v_n = -`JUMP_V;
			end else begin
				v_n = 0;
			end
		end else begin
			v_n = v_n + int'(link.gravity);
			if (v_n > `VY_MAX) begin
				v_n = `VY_MAX; // Terminal speed
			end
		end
		if (link.wall[1] && (v_n < 0)) begin
			v_n = 0; // Head at top of screen
		end
		y_n = y_n + v_n;
		if (y_n < 0) begin
			y_n = 0;
		end

		pos_d.xy.x = 16'(x_n);
		pos_d.xy.y = 16'(y_n);
		vy_d       = 16'(v_n);
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pos_q.raw <= START;
			vy_q      <= '0;
		end else if (tick) begin
			pos_q <= pos_d;
			vy_q  <= vy_d;
		end // Held between ticks
	end

	assign link.pos = pos_q;

	// Left wall from collision must block walking left
	a_left_wall: assert property (@(posedge clock) disable iff (!arst_n)
		(tick && link.wall[2] && !link.hit) |=> (pos_q.xy.x >= $past(pos_q.xy.x)))
		else $error("x moved left through the left wall");

	a_vy_cap: assert property (@(posedge clock) disable iff (!arst_n)
		vy_q <= `VY_MAX)
		else $error("Falling speed above cap");
endmodule

// File: mmio.sv
`timescale 1ns/100ps
`include "game_defines.svh"

module mmio (
	input  logic        clock,
	input  logic        arst_n,
	input  logic [12:0] address,
	input  logic [31:0] data_in,
	input  logic        wren,
	input  logic [3:0]  ctrl_p1,
	input  logic [3:0]  ctrl_p2,
	output logic [31:0] data_out,
	output logic [31:0] pos_p1,
	output logic [31:0] pos_p2
);
	logic [4:0]          blk_sel;       // Coprocessor block
	logic [4:0]          reg_sel;       // Register inside block
	logic                mem_wr;
	logic                cfg_wr;
	logic [31:0]         mem_q;
	logic [15:0]         gravity_q;
	game_pkg::pos_word_u stage_pos_q;
	game_pkg::pos_word_u stage_size_q;
	logic [1:0][3:0]     btn_meta;      // First sync stage, index is player
	logic [1:0][3:0]     btn_sync;
	game_pkg::pos_word_u size_p1;
	game_pkg::pos_word_u size_p2;
	logic [3:0]          coll_p1;
	logic [3:0]          coll_p2;
	logic                atk1_hit;
	logic                atk2_hit;
	logic signed [15:0]  atk1_knock;
	logic signed [15:0]  atk2_knock;
	game_pkg::pos_word_u rd_d;
	game_pkg::pos_word_u rd_q;
	logic                rd_mem_q;      // Last read was memory space

	assign blk_sel = address[11:7];
	assign reg_sel = address[6:2];
	assign mem_wr  = wren && !address[12];
	assign cfg_wr  = wren && address[12] && (blk_sel == `SEL_CFG);

	// Config block, written over the bus
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			gravity_q        <= 16'(`GRAVITY_RST);
			stage_pos_q.raw  <= `STAGE_POS_RST;
			stage_size_q.raw <= `STAGE_SIZE_RST;
		end else if (cfg_wr) begin
			case (reg_sel)
				`CFG_GRAVITY:    gravity_q        <= data_in[15:0];
				`CFG_STAGE_POS:  stage_pos_q.raw  <= data_in;
				`CFG_STAGE_SIZE: stage_size_q.raw <= data_in;
				default: ; // Unmapped, dropped
			endcase
		end
	end

	// Two flop button synchronizer
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			btn_meta <= '0;
			btn_sync <= '0;
		end else begin
			btn_meta <= {ctrl_p2, ctrl_p1};
			btn_sync <= btn_meta;
		end
	end

	assign size_p1.raw = `P1_SIZE;
	assign size_p2.raw = `P2_SIZE;

	phys_if link_p1 ();
	phys_if link_p2 ();

	// Attack results cross over to the opponent's physics
	assign link_p1.ctrl    = btn_sync[0];
	assign link_p1.wall    = coll_p1;
	assign link_p1.hit     = atk2_hit;
	assign link_p1.knock   = atk2_knock;
	assign link_p1.gravity = gravity_q;
	assign link_p2.ctrl    = btn_sync[1];
	assign link_p2.wall    = coll_p2;
	assign link_p2.hit     = atk1_hit;
	assign link_p2.knock   = atk1_knock;
	assign link_p2.gravity = gravity_q;

	physics_coprocessor #(.START(`P1_START)) u_phys_p1 (
		.clock  (clock),
		.arst_n (arst_n),
		.link   (link_p1)
	);

	physics_coprocessor #(.START(`P2_START)) u_phys_p2 (
		.clock  (clock),
		.arst_n (arst_n),
		.link   (link_p2)
	);

	collision u_coll_p1 (
		.player_pos  (link_p1.pos),
		.player_size (size_p1),
		.stage_pos   (stage_pos_q),
		.stage_size  (stage_size_q),
		.coll        (coll_p1)
	);

	collision u_coll_p2 (
		.player_pos  (link_p2.pos),
		.player_size (size_p2),
		.stage_pos   (stage_pos_q),
		.stage_size  (stage_size_q),
		.coll        (coll_p2)
	);

	attack_coprocessor u_atk_p1 (
		.clock    (clock),
		.arst_n   (arst_n),
		.own_pos  (link_p1.pos),
		.own_size (size_p1),
		.foe_pos  (link_p2.pos),
		.foe_size (size_p2),
		.controls (btn_sync[0]),
		.hit      (atk1_hit),
		.knock    (atk1_knock)
	);

	attack_coprocessor u_atk_p2 (
		.clock    (clock),
		.arst_n   (arst_n),
		.own_pos  (link_p2.pos),
		.own_size (size_p2),
		.foe_pos  (link_p1.pos),
		.foe_size (size_p1),
		.controls (btn_sync[1]),
		.hit      (atk2_hit),
		.knock    (atk2_knock)
	);

	dmem u_dmem (
		.clock   (clock),
		.address (address[11:0]),
		.data    (data_in),
		.wren    (mem_wr),
		.q       (mem_q)
	);

	// Coprocessor read mux, register 0 of each block unless noted
	always_comb begin
		rd_d.raw = '0;
		case (blk_sel)
			`SEL_POS1:  if (reg_sel == '0) rd_d = link_p1.pos;
			`SEL_POS2:  if (reg_sel == '0) rd_d = link_p2.pos;
			`SEL_CTRL1: if (reg_sel == '0) rd_d.raw = {28'd0, btn_sync[0]};
			`SEL_CTRL2: if (reg_sel == '0) rd_d.raw = {28'd0, btn_sync[1]};
			`SEL_COLL1: if (reg_sel == '0) rd_d.raw = {28'd0, coll_p1};
			`SEL_COLL2: if (reg_sel == '0) rd_d.raw = {28'd0, coll_p2};
			`SEL_ATK1:  if (reg_sel == '0) rd_d.raw = {atk1_knock, 15'd0, atk1_hit};
			`SEL_ATK2:  if (reg_sel == '0) rd_d.raw = {atk2_knock, 15'd0, atk2_hit};
			`SEL_CFG: begin
				case (reg_sel)
					`CFG_GRAVITY:    rd_d.raw = {16'd0, gravity_q};
					`CFG_STAGE_POS:  rd_d     = stage_pos_q;
					`CFG_STAGE_SIZE: rd_d     = stage_size_q;
					default: ;
				endcase
			end
			default: ; // Unmapped block reads 0
		endcase
	end

	// Same one cycle latency as the memory's registered q
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rd_q.raw <= '0;
			rd_mem_q <= 1'b0;
		end else begin
			rd_q     <= rd_d;
			rd_mem_q <= !address[12];
		end
	end

	assign data_out = rd_mem_q ? mem_q : rd_q.raw;
	assign pos_p1   = link_p1.pos.raw;
	assign pos_p2   = link_p2.pos.raw;

	// Writes into coprocessor space outside the config block leave config alone
	a_cfg_only: assert property (@(posedge clock) disable iff (!arst_n)
		(wren && address[12] && (blk_sel != `SEL_CFG))
		|=> $stable({gravity_q, stage_pos_q.raw, stage_size_q.raw}))
		else $error("Config changed by a write to another block");
endmodule

// File: tb_clock.sv
`timescale 1ns/100ps

// Free running clock and power-on reset for the testbench
module tb_clock #(
	parameter real PERIOD     = 100.0, // ns
	parameter int  RST_CYCLES = 2
) (
	output logic clock,
	output logic arst_n
);
	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2.0) clock = ~clock;
	end

	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clock);
		arst_n <= 1'b1; // Released just after the edge
	end
endmodule

// File: tb_mmio.sv
`timescale 1ns/100ps
`include "game_defines.svh"

module tb_mmio;
	localparam int WAIT_MAX = 600; // Cycles allowed per wait loop

	logic        clock;
	logic        arst_n;
	logic [12:0] address;
	logic [31:0] data_in;
	logic        wren;
	logic [3:0]  ctrl_p1;
	logic [3:0]  ctrl_p2;
	logic [31:0] data_out;
	logic [31:0] pos_p1;
	logic [31:0] pos_p2;
	logic [31:0] lfsr_state;
	logic [31:0] mem_model [4096]; // Last word written to each address

	tb_clock #(.PERIOD(100.0), .RST_CYCLES(2)) u_clock (
		.clock  (clock),
		.arst_n (arst_n)
	);

	mmio u_mmio (
		.clock    (clock),
		.arst_n   (arst_n),
		.address  (address),
		.data_in  (data_in),
		.wren     (wren),
		.ctrl_p1  (ctrl_p1),
		.ctrl_p2  (ctrl_p2),
		.data_out (data_out),
		.pos_p1   (pos_p1),
		.pos_p2   (pos_p2)
	);

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v          = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Coprocessor space address with bit 12 set
	function automatic logic [12:0] cop_addr(input logic [4:0] blk, input logic [4:0] rsel);
		return {1'b1, blk, rsel, 2'b00};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		abort_run($sformatf("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act));
	endtask

	task automatic check_equal(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else report_mismatch(name, exp, act);
	endtask

	task automatic bus_write(input logic [12:0] addr, input logic [31:0] wdata);
		@(posedge clock);
		address <= addr;
		data_in <= wdata;
		wren    <= 1'b1;
		@(posedge clock); // Write lands on this edge
		wren    <= 1'b0;
	endtask

	task automatic bus_read(input logic [12:0] addr, output logic [31:0] rdata);
		@(posedge clock);
		address <= addr;
		wren    <= 1'b0;
		@(posedge clock); // Read data registered here
		@(negedge clock);
		rdata = data_out;
	endtask

	task automatic poll_bit(input string name, input logic [12:0] addr, input int bit_n,
		input logic val);
		logic [31:0] rdata;
		int          t;
		t = 0;
		bus_read(addr, rdata);
		while (rdata[bit_n] !== val) begin
			t++;
			if (t > WAIT_MAX) begin
				abort_run($sformatf("%s: bit %0d never became %0b", name, bit_n, val));
			end
			bus_read(addr, rdata);
		end
	endtask

	// Each x change of one player must be one step with y unchanged
	task automatic watch_steps(input string name, input bit second, input int step,
		input int count);
		logic [31:0] prev;
		logic [31:0] now;
		int          changes;
		int          t;
		@(negedge clock);
		prev    = second ? pos_p2 : pos_p1;
		changes = 0;
		t       = 0;
		while (changes < count) begin
			@(negedge clock);
			now = second ? pos_p2 : pos_p1;
			check_equal({name, "_y"}, {16'd0, prev[15:0]}, {16'd0, now[15:0]});
			if (now[31:16] !== prev[31:16]) begin
				check_equal({name, "_x"}, {16'd0, prev[31:16] + 16'(step)}, {16'd0, now[31:16]});
				changes++;
			end
			prev = now;
			t++;
			if (t > WAIT_MAX) begin
				abort_run($sformatf("%s: x stopped changing", name));
			end
		end
	endtask

	task automatic release_buttons();
		@(posedge clock);
		ctrl_p1 <= '0;
		ctrl_p2 <= '0;
		repeat (`PHYS_DIV + 3) @(posedge clock); // Sync delay plus one tick
	endtask

	initial begin
		logic [31:0] rdata;
		logic [31:0] mdata;
		logic [11:0] maddr [8];
		logic [31:0] p1_prev;
		logic [31:0] p2_prev;
		logic        floor1;
		logic        floor2;
		int          t;
		lfsr_state = 32'h210b;
		address    <= '0;
		data_in    <= '0;
		wren       <= 1'b0;
		ctrl_p1    <= '0;
		ctrl_p2    <= '0;

		t = 0;
		while (arst_n !== 1'b1) begin
			@(posedge clock);
			t++;
			if (t > WAIT_MAX) begin
				abort_run("Reset was never released");
			end
		end
		@(negedge clock);
		check_equal("start_p1", `P1_START, pos_p1);
		check_equal("start_p2", `P2_START, pos_p2);

		// Both fall until the stage catches them
		p1_prev = pos_p1;
		p2_prev = pos_p2;
		floor1  = 1'b0;
		floor2  = 1'b0;
		t       = 0;
		while (!(floor1 && floor2)) begin
			bus_read(cop_addr(`SEL_COLL1, 5'd0), rdata);
			floor1 = rdata[0];
			bus_read(cop_addr(`SEL_COLL2, 5'd0), rdata);
			floor2 = rdata[0];
			assert (pos_p1[15:0] >= p1_prev[15:0]) else report_mismatch("fall_p1", p1_prev, pos_p1);
			assert (pos_p2[15:0] >= p2_prev[15:0]) else report_mismatch("fall_p2", p2_prev, pos_p2);
			p1_prev = pos_p1;
			p2_prev = pos_p2;
			t++;
			if (t > WAIT_MAX) begin
				abort_run("Floor bit never appeared for both players");
			end
		end
		repeat (4 * `PHYS_DIV) begin // Standing still now
			@(negedge clock);
			check_equal("landed_p1", p1_prev, pos_p1);
			check_equal("landed_p2", p2_prev, pos_p2);
		end

		// Random words into random memory addresses
		for (int i = 0; i < 8; i++) begin
			take_bits(12, mdata);
			maddr[i] = mdata[11:0];
			take_bits(32, mdata);
			mem_model[maddr[i]] = mdata; // Repeated address keeps last word
			bus_write({1'b0, maddr[i]}, mdata);
		end
		for (int i = 0; i < 8; i++) begin
			bus_read({1'b0, maddr[i]}, rdata);
			check_equal($sformatf("mem_0x%03h", maddr[i]), mem_model[maddr[i]], rdata);
		end

		@(posedge clock);
		ctrl_p1 <= 4'(1 << `BTN_RIGHT);
		watch_steps("walk_right", 1'b0, `WALK_STEP, 4);
		release_buttons();
		ctrl_p1 <= 4'(1 << `BTN_LEFT);
		watch_steps("walk_left", 1'b0, -`WALK_STEP, 4);
		release_buttons();

		// Player 1 hits player 2 and pushes it right
		ctrl_p1 <= 4'(1 << `BTN_ATTACK);
		poll_bit("atk1_hit", cop_addr(`SEL_ATK1, 5'd0), 0, 1'b1);
		watch_steps("knock_p2", 1'b1, `KNOCK, 2);
		@(posedge clock);
		ctrl_p1 <= '0;
		poll_bit("atk1_release", cop_addr(`SEL_ATK1, 5'd0), 0, 1'b0);
		release_buttons();

		// With zero gravity a jump keeps rising
		bus_write(cop_addr(`SEL_CFG, `CFG_GRAVITY), 32'd0);
		bus_read(cop_addr(`SEL_CFG, `CFG_GRAVITY), rdata);
		check_equal("cfg_gravity", 32'd0, rdata);
		@(posedge clock);
		ctrl_p1 <= 4'(1 << `BTN_JUMP);
		@(negedge clock);
		p1_prev = pos_p1;
		t       = 0;
		while (pos_p1[15:0] === p1_prev[15:0]) begin
			@(negedge clock);
			t++;
			if (t > WAIT_MAX) begin
				abort_run("Player 1 never left the floor");
			end
		end
		assert (pos_p1[15:0] < p1_prev[15:0]) else report_mismatch("jump_up", p1_prev, pos_p1);
		release_buttons();
		repeat (16 * `PHYS_DIV) begin
			p1_prev = pos_p1;
			@(negedge clock);
			assert (pos_p1[15:0] <= p1_prev[15:0]) else report_mismatch("no_fall", p1_prev, pos_p1);
		end

		// Button registers and an unmapped block
		@(posedge clock);
		ctrl_p1 <= 4'b1010;
		ctrl_p2 <= 4'b0101;
		repeat (2) @(posedge clock); // Synchronizer stages
		bus_read(cop_addr(`SEL_CTRL1, 5'd0), rdata);
		check_equal("ctrl_p1_read", 32'h0000_000A, rdata);
		bus_read(cop_addr(`SEL_CTRL2, 5'd0), rdata);
		check_equal("ctrl_p2_read", 32'h0000_0005, rdata);
		bus_read(cop_addr(5'd7, 5'd0), rdata);
		check_equal("unmapped_read", 32'd0, rdata);

		$display("TESTS PASSED");
		$finish;
	end
endmodule

// File: tb.f
+incdir+.
game_pkg.sv
phys_if.sv
dmem.sv
collision.sv
attack_coprocessor.sv
physics_coprocessor.sv
mmio.sv
tb_clock.sv
tb_mmio.sv

// File: Bender.yml
package:
  name: mmio_hub

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - game_pkg.sv
      - phys_if.sv
      - dmem.sv
      - collision.sv
      - attack_coprocessor.sv
      - physics_coprocessor.sv
      - mmio.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock.sv
      - tb_mmio.sv
